// File: common/aes_pkg.sv
`default_nettype none

package aes_pkg;

	localparam int NUM_ROUNDS = 10;

	// ------------------------------------------------------------------------
	// data types
	// ------------------------------------------------------------------------

	// one block, seen flat or as four column words
	typedef union packed {
		logic [127:0]     flat;
		logic [0:3][31:0] col;   // col[0] sits in the top word
	} aes_block_u;

	// round key 0 in the top 128 bits, round key 10 at the bottom
	typedef logic [0:NUM_ROUNDS][127:0] aes_rkeys_t;

	typedef struct packed {
		logic       key_load;   // one-cycle pulse
		logic       start;      // one-cycle pulse
		aes_block_u key;
		aes_block_u din;
	} aes_ctrl_t;

	// ------------------------------------------------------------------------
	// register map, byte offsets
	// ------------------------------------------------------------------------
	localparam logic [5:0] REG_CTRL   = 6'h00;
	localparam logic [5:0] REG_STATUS = 6'h04;
	localparam logic [5:0] REG_KEY0   = 6'h10;   // KEY0..3 up to 0x1c
	localparam logic [5:0] REG_DIN0   = 6'h20;   // DIN0..3 up to 0x2c
	localparam logic [5:0] REG_DOUT0  = 6'h30;   // DOUT0..3 up to 0x3c

	localparam int CTRL_KEY_LOAD = 0;
	localparam int CTRL_START    = 1;

	// round constant, only the top byte of the word is non-zero
	function automatic logic [7:0] rcon(input logic [3:0] idx);
		case (idx)
			4'd0:    return 8'h01;
			4'd1:    return 8'h02;
			4'd2:    return 8'h04;
			4'd3:    return 8'h08;
			4'd4:    return 8'h10;
			4'd5:    return 8'h20;
			4'd6:    return 8'h40;
			4'd7:    return 8'h80;
			4'd8:    return 8'h1b;
			4'd9:    return 8'h36;
			default: return 8'h00;
		endcase
	endfunction

endpackage

`default_nettype wire

// File: common/axil_pkg.sv
`default_nettype none

package axil_pkg;

	// response codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// address channels carry the full bus address, blocks decode what they need
	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] data;   // no strobes, always a full word
	} axil_w_t;

	typedef struct packed {
		logic       valid;
		logic [1:0] resp;
	} axil_b_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] data;
		logic [1:0]  resp;
	} axil_r_t;

endpackage

`default_nettype wire

// File: aes/aes_sbox.sv
`timescale 1ns/1ps
`default_nettype none

// forward S-box, x^254 in GF(2^8) then the affine map
module aes_sbox (
	input  wire [7:0]  i_byte,
	output logic [7:0] o_byte
);

	// multiply mod x^8 + x^4 + x^3 + x + 1
	function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
		logic [7:0] p;
		logic [7:0] aa;
		p  = 8'h00;
		aa = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				p = p ^ aa;
			aa = {aa[6:0], 1'b0} ^ (aa[7] ? 8'h1b : 8'h00);
		end
		return p;
	endfunction

	logic [7:0] sq;    // running square, x^(2^k)
	logic [7:0] inv;   // product of squares

	// x^254 = x^2 * x^4 * ... * x^128, zero maps to zero
	always_comb begin
		sq  = i_byte;
		inv = 8'h01;
		for (int k = 1; k < 8; k++) begin
			sq  = gf_mul(sq, sq);
			inv = gf_mul(inv, sq);
		end
	end

	// affine: b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 63
	assign o_byte = inv
		^ {inv[6:0], inv[7]}
		^ {inv[5:0], inv[7:6]}
		^ {inv[4:0], inv[7:5]}
		^ {inv[3:0], inv[7:4]}
		^ 8'h63;

endmodule

`default_nettype wire

// File: aes/aes_keyex.sv
`timescale 1ns/1ps
`default_nettype none

module aes_keyex
	import aes_pkg::*;
(
	input  wire              i_clk,
	input  wire              i_rst,
	input  wire              i_key_load,
	input  wire aes_block_u  i_key,
	output aes_rkeys_t       o_rkeys,
	output logic             o_key_ok,
	output logic             o_sbox_use,    // window request to the cipher
	output logic [31:0]      o_sbox_din,
	input  wire [31:0]       i_sbox_dout
);

	logic [3:0]          cnt;     // round keys registered so far
	aes_block_u          cur;     // key the step works from
	aes_block_u          last;    // newest round key
	aes_block_u          nxt;
	logic [1:10][127:0]  rk_sr;   // round keys 1..10, shifted in from the bottom
	logic [31:0]         t;

	// first step runs straight off the input key
	assign cur = i_key_load ? i_key : last;

	assign o_sbox_use = i_key_load | (cnt != 4'd0 && cnt != NUM_ROUNDS);
	assign o_sbox_din = {cur.col[3][23:0], cur.col[3][31:24]};   // RotWord

	// SubWord result plus round constant
	assign t = i_sbox_dout ^ {rcon(i_key_load ? 4'd0 : cnt), 24'h000000};

	always_comb begin
		nxt.col[0] = cur.col[0] ^ t;
		for (int i = 1; i < 4; i++)
			nxt.col[i] = cur.col[i] ^ nxt.col[i-1];   // chained words
	end

	// ------------------------------------------------------------------------
	// counter and round key store
	// ------------------------------------------------------------------------
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst)
			cnt <= 4'd0;
		else if (i_key_load)
			cnt <= 4'd1;           // restart, even mid-schedule
		else if (o_sbox_use)
			cnt <= cnt + 4'd1;     // stops at 10
	end

	always_ff @(posedge i_clk) begin
		if (o_sbox_use) begin
			last  <= nxt;
			rk_sr <= {rk_sr[2:10], nxt.flat};
		end
	end

	// key_ok held off during the load pulse itself
	assign o_key_ok = (cnt == NUM_ROUNDS) & ~i_key_load;
	assign o_rkeys  = {i_key.flat, rk_sr};   // rk0 is the key register

endmodule

`default_nettype wire

// File: aes/aes_cipher.sv
`timescale 1ns/1ps
`default_nettype none

module aes_cipher
	import aes_pkg::*;
(
	input  wire              i_clk,
	input  wire              i_rst,
	input  wire              i_start,
	input  wire aes_block_u  i_din,
	input  wire aes_rkeys_t  i_rkeys,
	input  wire              i_key_ok,
	input  wire              i_kx_sbox_use,
	input  wire [31:0]       i_kx_sbox_din,
	output logic [31:0]      o_kx_sbox_dout,
	output aes_block_u       o_dout,
	output logic             o_done,
	output logic             o_busy,
	output logic             o_start_err
);

	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// one column times the fixed 2 3 1 1 matrix
	function automatic logic [31:0] mix_col(input logic [31:0] w);
		logic [0:3][7:0] a;
		a = w;
		return {xtime(a[0]) ^ xtime(a[1]) ^ a[1] ^ a[2] ^ a[3],
			a[0] ^ xtime(a[1]) ^ xtime(a[2]) ^ a[2] ^ a[3],
			a[0] ^ a[1] ^ xtime(a[2]) ^ xtime(a[3]) ^ a[3],
			xtime(a[0]) ^ a[0] ^ a[1] ^ a[2] ^ xtime(a[3])};
	endfunction

	aes_block_u   state;
	aes_block_u   sb_in;
	wire [127:0]  sb_dout;
	aes_block_u   sub;     // after SubBytes
	aes_block_u   sr;      // after ShiftRows
	aes_block_u   mc;      // after MixColumns
	aes_block_u   nxt;
	logic [3:0]   rnd;     // round being computed, 1..10
	logic         start_ok;

	// ------------------------------------------------------------------------
	// S-box bank, column 0 lent to the key expander
	// ------------------------------------------------------------------------
	always_comb begin
		sb_in = state;
		if (i_kx_sbox_use)
			sb_in.col[0] = i_kx_sbox_din;   // cipher idle, start needs key_ok
	end

	for (genvar i = 0; i < 16; i++) begin : g_sbox
		aes_sbox u_sbox (
			.i_byte (sb_in.flat[8*i +: 8]),
			.o_byte (sb_dout[8*i +: 8])
		);
	end

	assign o_kx_sbox_dout = sb_dout[127:96];

	// ------------------------------------------------------------------------
	// round datapath
	// ------------------------------------------------------------------------
	always_comb begin
		sub.flat = sb_dout;
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++)
				sr.col[c][31-8*r -: 8] = sub.col[(c+r)%4][31-8*r -: 8];   // row r left by r
			mc.col[c] = mix_col(sr.col[c]);
		end
		// last round skips MixColumns
		nxt.flat = ((rnd == NUM_ROUNDS) ? sr.flat : mc.flat) ^ i_rkeys[rnd];
	end

	// one block in flight, extra starts are flagged not queued
	assign start_ok    = i_start & i_key_ok & ~o_busy;
	assign o_start_err = i_start & ~start_ok;
	assign o_done      = o_busy & (rnd == NUM_ROUNDS);
	assign o_dout      = nxt;   // valid with o_done

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			o_busy <= 1'b0;
			rnd    <= 4'd0;
		end else if (start_ok) begin
			o_busy <= 1'b1;
			rnd    <= 4'd1;
		end else if (o_done) begin
			o_busy <= 1'b0;
			rnd    <= 4'd0;
		end else if (o_busy) begin
			rnd <= rnd + 4'd1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (start_ok)
			state.flat <= i_din.flat ^ i_rkeys[0];   // initial AddRoundKey
		else if (o_busy)
			state <= nxt;
	end

endmodule

`default_nettype wire

// File: verilog/aes_regs.sv
`timescale 1ns/1ps
`default_nettype none

module aes_regs
	import aes_pkg::*, axil_pkg::*;
#(
	parameter int ADDR_W = 8
) (
	input  wire              i_clk,
	input  wire              i_rst,
	input  wire axil_aw_t    i_aw,
	output logic             o_aw_ready,
	input  wire axil_w_t     i_w,
	output logic             o_w_ready,
	output axil_b_t          o_b,
	input  wire              i_b_ready,
	output aes_ctrl_t        o_ctrl,
	output logic             o_err_clr
);

	logic              aw_full;
	logic [ADDR_W-1:0] aw_addr;
	logic              w_full;
	logic [31:0]       w_data;
	logic              do_wr;
	logic [5:0]        off;
	logic              in_map;
	logic              wr_ctrl;
	logic              wr_key;
	logic              wr_din;
	logic              key_load_q;
	logic              start_q;
	aes_block_u        key_q;
	aes_block_u        din_q;

	// ------------------------------------------------------------------------
	// AW and W holding, write once both are in
	// ------------------------------------------------------------------------
	assign o_aw_ready = ~aw_full & ~o_b.valid;   // nothing new while B pending
	assign o_w_ready  = ~w_full & ~o_b.valid;
	assign do_wr      = aw_full & w_full;

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			aw_full <= 1'b0;
			w_full  <= 1'b0;
		end else begin
			aw_full <= ~do_wr & (aw_full | (i_aw.valid & o_aw_ready));
			w_full  <= ~do_wr & (w_full | (i_w.valid & o_w_ready));
		end
	end

	// address decode, bits above the 64-byte map must be zero
	assign off     = aw_addr[5:0];
	assign in_map  = (aw_addr >> 6) == '0;
	assign wr_ctrl = in_map && off == REG_CTRL;
	assign wr_key  = in_map && off[5:4] == REG_KEY0[5:4] && off[1:0] == 2'b00;
	assign wr_din  = in_map && off[5:4] == REG_DIN0[5:4] && off[1:0] == 2'b00;

	always_ff @(posedge i_clk) begin
		if (i_aw.valid && o_aw_ready)
			aw_addr <= i_aw.addr[ADDR_W-1:0];
		if (i_w.valid && o_w_ready)
			w_data <= i_w.data;
		if (do_wr && wr_key)
			key_q.col[off[3:2]] <= w_data;   // KEY0 is the top word
		if (do_wr && wr_din)
			din_q.col[off[3:2]] <= w_data;
	end

	// ------------------------------------------------------------------------
	// control pulses and write response
	// ------------------------------------------------------------------------
	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			key_load_q <= 1'b0;
			start_q    <= 1'b0;
			o_b        <= '0;
		end else begin
			key_load_q <= do_wr & wr_ctrl & w_data[CTRL_KEY_LOAD];
			start_q    <= do_wr & wr_ctrl & w_data[CTRL_START];
			if (do_wr) begin
				o_b.valid <= 1'b1;
				// STATUS, DOUT and holes are not writable
				o_b.resp  <= (wr_ctrl | wr_key | wr_din) ? RESP_OKAY : RESP_SLVERR;
			end else if (i_b_ready) begin
				o_b.valid <= 1'b0;
			end
		end
	end

	assign o_ctrl.key_load = key_load_q;
	assign o_ctrl.start    = start_q;
	assign o_ctrl.key      = key_q;
	assign o_ctrl.din      = din_q;
	assign o_err_clr       = key_load_q;   // a new key clears the error flag

endmodule

`default_nettype wire

// File: verilog/aes_result.sv
`timescale 1ns/1ps
`default_nettype none

module aes_result
	import aes_pkg::*, axil_pkg::*;
#(
	parameter int ADDR_W = 8
) (
	input  wire              i_clk,
	input  wire              i_rst,
	input  wire axil_ar_t    i_ar,
	output logic             o_ar_ready,
	output axil_r_t          o_r,
	input  wire              i_r_ready,
	input  wire aes_block_u  i_dout,
	input  wire              i_done,
	input  wire              i_busy,
	input  wire              i_key_ok,
	input  wire              i_start_err,
	input  wire              i_err_clr
);

	logic [ADDR_W-1:0] ar_addr;
	logic [5:0]        off;
	logic              busy_d;    // for the start edge
	logic              done_q;
	logic              err_q;
	aes_block_u        dout_q;
	logic [31:0]       status;
	logic [31:0]       rd_data;
	logic              rd_ok;

	assign o_ar_ready = ~o_r.valid;
	assign ar_addr    = i_ar.addr[ADDR_W-1:0];
	assign off        = ar_addr[5:0];
	assign status     = {28'd0, err_q, done_q, i_busy, i_key_ok};

	// ------------------------------------------------------------------------
	// read decode, key and data read back as zero
	// ------------------------------------------------------------------------
	always_comb begin
		rd_data = 32'd0;
		rd_ok   = 1'b0;
		if ((ar_addr >> 6) == '0 && off[1:0] == 2'b00) begin
			if (off == REG_STATUS) begin
				rd_data = status;
				rd_ok   = 1'b1;
			end else if (off[5:4] == REG_DOUT0[5:4]) begin
				rd_data = dout_q.col[off[3:2]];
				rd_ok   = 1'b1;
			end else if (off == REG_CTRL || off[5:4] == REG_KEY0[5:4]
					|| off[5:4] == REG_DIN0[5:4]) begin
				rd_ok = 1'b1;   // write-only, no echo
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_done)
			dout_q <= i_dout;   // ciphertext capture
	end

	always_ff @(posedge i_clk or posedge i_rst) begin
		if (i_rst) begin
			busy_d <= 1'b0;
			done_q <= 1'b0;
			err_q  <= 1'b0;
			o_r    <= '0;
		end else begin
			busy_d <= i_busy;
			if (i_done)
				done_q <= 1'b1;
			else if (i_busy && !busy_d)
				done_q <= 1'b0;   // next block accepted
			// key load under a running block is refused, so it flags too
			if (i_start_err || (i_err_clr && i_busy))
				err_q <= 1'b1;
			else if (i_err_clr)
				err_q <= 1'b0;
			if (i_ar.valid && o_ar_ready) begin
				o_r.valid <= 1'b1;
				o_r.data  <= rd_data;
				o_r.resp  <= rd_ok ? RESP_OKAY : RESP_SLVERR;
			end else if (i_r_ready) begin
				o_r.valid <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/aes_top.sv
`timescale 1ns/1ps
`default_nettype none

module aes_top
	import aes_pkg::*, axil_pkg::*;
#(
	parameter int ADDR_W = 8
) (
	input  wire            i_clk,
	input  wire            i_rst,
	input  wire axil_aw_t  i_aw,
	output logic           o_aw_ready,
	input  wire axil_w_t   i_w,
	output logic           o_w_ready,
	output axil_b_t        o_b,
	input  wire            i_b_ready,
	input  wire axil_ar_t  i_ar,
	output logic           o_ar_ready,
	output axil_r_t        o_r,
	input  wire            i_r_ready
);

	aes_ctrl_t   ctrl;
	logic        err_clr;
	logic        kx_load;
	aes_rkeys_t  rkeys;
	logic        key_ok;
	logic        sbox_use;
	logic [31:0] sbox_din;
	logic [31:0] sbox_dout;
	aes_block_u  dout;
	logic        done;
	logic        busy;
	logic        start_err;

	// ------------------------------------------------------------------------
	// decode
	// ------------------------------------------------------------------------
	aes_regs #(.ADDR_W(ADDR_W)) u_regs (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_aw       (i_aw),
		.o_aw_ready (o_aw_ready),
		.i_w        (i_w),
		.o_w_ready  (o_w_ready),
		.o_b        (o_b),
		.i_b_ready  (i_b_ready),
		.o_ctrl     (ctrl),
		.o_err_clr  (err_clr)
	);

	// ------------------------------------------------------------------------
	// execute
	// ------------------------------------------------------------------------
	assign kx_load = ctrl.key_load & ~busy;   // round keys stay put under a block

	aes_keyex u_keyex (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_key_load  (kx_load),
		.i_key       (ctrl.key),
		.o_rkeys     (rkeys),
		.o_key_ok    (key_ok),
		.o_sbox_use  (sbox_use),
		.o_sbox_din  (sbox_din),
		.i_sbox_dout (sbox_dout)
	);

	aes_cipher u_cipher (
		.i_clk          (i_clk),
		.i_rst          (i_rst),
		.i_start        (ctrl.start),
		.i_din          (ctrl.din),
		.i_rkeys        (rkeys),
		.i_key_ok       (key_ok),
		.i_kx_sbox_use  (sbox_use),
		.i_kx_sbox_din  (sbox_din),
		.o_kx_sbox_dout (sbox_dout),
		.o_dout         (dout),
		.o_done         (done),
		.o_busy         (busy),
		.o_start_err    (start_err)
	);

	// ------------------------------------------------------------------------
	// result
	// ------------------------------------------------------------------------
	aes_result #(.ADDR_W(ADDR_W)) u_result (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_ar        (i_ar),
		.o_ar_ready  (o_ar_ready),
		.o_r         (o_r),
		.i_r_ready   (i_r_ready),
		.i_dout      (dout),
		.i_done      (done),
		.i_busy      (busy),
		.i_key_ok    (key_ok),
		.i_start_err (start_err),
		.i_err_clr   (err_clr)
	);

endmodule

`default_nettype wire

// File: tb/tb_aes_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aes_top
	import aes_pkg::*, axil_pkg::*;
();

	localparam int  NUM_VEC         = 4;
	localparam time CLK_PERIOD      = 100;
	localparam int  WATCHDOG_CYCLES = NUM_VEC * 400 + 1500;   // vectors plus side tests

	localparam logic [31:0] A_CTRL     = {26'd0, REG_CTRL};
	localparam logic [31:0] A_STATUS   = {26'd0, REG_STATUS};
	localparam logic [31:0] A_KEY0     = {26'd0, REG_KEY0};
	localparam logic [31:0] A_DIN0     = {26'd0, REG_DIN0};
	localparam logic [31:0] A_DOUT0    = {26'd0, REG_DOUT0};
	localparam logic [31:0] A_UNMAPPED = 32'h0000_0008;   // hole between STATUS and KEY0

	// STATUS bits
	localparam logic [31:0] ST_KEY_OK = 32'h1;
	localparam logic [31:0] ST_BUSY   = 32'h2;
	localparam logic [31:0] ST_DONE   = 32'h4;
	localparam logic [31:0] ST_ERR    = 32'h8;

	typedef struct packed {
		logic [127:0] key;
		logic [127:0] pt;
		logic [127:0] ct;   // expected
	} vec_t;

	logic         i_clk;
	logic         i_rst;
	axil_aw_t     i_aw;
	axil_w_t      i_w;
	axil_ar_t     i_ar;
	logic         i_b_ready;
	logic         i_r_ready;
	logic         o_aw_ready;
	logic         o_w_ready;
	logic         o_ar_ready;
	axil_b_t      o_b;
	axil_r_t      o_r;

	logic [127:0] vec_mem [0:3*NUM_VEC-1];   // flat image of the data file
	vec_t         vecs [0:NUM_VEC-1];
	logic [31:0]  rng;
	bit           bp_en;          // random back-pressure and AW/W gaps
	int           errors   = 0;
	int           n_checks = 0;
	int           n_tests  = 0;
	int           test_err = 0;   // error count when the test began
	int           n_wr     = 0;
	int           n_rd     = 0;
	int           n_b      = 0;   // B responses raised by the DUT
	int           n_r      = 0;
	bit           b_held   = 1'b0;   // B beat still waiting from the last edge
	bit           r_held   = 1'b0;

	aes_top #(.ADDR_W(8)) u_dut (
		.i_clk      (i_clk),
		.i_rst      (i_rst),
		.i_aw       (i_aw),
		.o_aw_ready (o_aw_ready),
		.i_w        (i_w),
		.o_w_ready  (o_w_ready),
		.o_b        (o_b),
		.i_b_ready  (i_b_ready),
		.i_ar       (i_ar),
		.o_ar_ready (o_ar_ready),
		.o_r        (o_r),
		.i_r_ready  (i_r_ready)
	);

	initial begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	// responses offered on the bus, a beat held under back-pressure counts once
	always @(posedge i_clk) begin
		if (o_b.valid && !b_held)
			n_b++;
		if (o_r.valid && !r_held)
			n_r++;
		b_held = o_b.valid && !i_b_ready;
		r_held = o_r.valid && !i_r_ready;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
		$display("*** FAILED ***");
		$finish;
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic int pick_delay();
		return bp_en ? int'(next_rand() % 32'd4) : 0;   // 0..3 cycles
	endfunction

	task automatic check_eq(input string name, input logic [127:0] got, input logic [127:0] exp);
		n_checks++;
		assert (got === exp) else begin
			$display("Fail %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		n_checks++;
		assert (cond) else begin
			$display("Error at %0t ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic test_begin();
		test_err = errors;
	endtask

	task automatic test_end(input string name);
		n_tests++;
		$display("test %0d %s: %0d error(s)", n_tests, name, errors - test_err);
	endtask

	// ------------------------------------------------------------------------
	// AXI4-Lite driver tasks start and end 5 ns after a rising edge
	// ------------------------------------------------------------------------
	task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int w_delay;
		int b_delay;
		int n;
		bit aw_done;
		bit w_done;
		bit got;
		w_delay = pick_delay();
		b_delay = pick_delay();
		check_true(!o_b.valid, "B valid high with no write outstanding");
		n_wr++;
		aw_done = 1'b0;
		w_done  = 1'b0;
		n       = 0;
		i_aw.addr  = addr;
		i_aw.valid = 1'b1;
		while (!(aw_done && w_done)) begin
			if (n == w_delay) begin
				i_w.data  = data;   // W trails AW by the gap
				i_w.valid = 1'b1;
			end
			@(posedge i_clk);
			if (i_aw.valid && o_aw_ready)
				aw_done = 1'b1;
			if (i_w.valid && o_w_ready)
				w_done = 1'b1;
			#5;
			if (aw_done)
				i_aw.valid = 1'b0;
			if (w_done)
				i_w.valid = 1'b0;
			n++;
		end
		n   = 0;
		got = 1'b0;
		while (!got) begin
			if (n == b_delay)
				i_b_ready = 1'b1;
			@(posedge i_clk);
			got  = o_b.valid && i_b_ready;
			resp = o_b.resp;
			#5;
			n++;
		end
		i_b_ready = 1'b0;
	endtask

	task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int r_delay;
		int n;
		bit got;
		r_delay = pick_delay();
		check_true(!o_r.valid, "R valid high with no read outstanding");
		n_rd++;
		i_ar.addr  = addr;
		i_ar.valid = 1'b1;
		got = 1'b0;
		while (!got) begin
			@(posedge i_clk);
			got = o_ar_ready;
			#5;
		end
		i_ar.valid = 1'b0;
		n   = 0;
		got = 1'b0;
		while (!got) begin
			if (n == r_delay)
				i_r_ready = 1'b1;
			@(posedge i_clk);
			got  = o_r.valid && i_r_ready;
			data = o_r.data;
			resp = o_r.resp;
			#5;
			n++;
		end
		i_r_ready = 1'b0;
	endtask

	task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
		logic [1:0] r;
		axil_write(addr, data, r);
		check_eq($sformatf("bresp @%0h", addr), r, RESP_OKAY);
	endtask

	task automatic read_reg(input logic [31:0] addr, input logic [31:0] exp, input string name);
		logic [31:0] d;
		logic [1:0]  r;
		axil_read(addr, d, r);
		check_eq({name, " rresp"}, r, RESP_OKAY);
		check_eq(name, d, exp);
	endtask

	// reads STATUS until the masked bits match
	task automatic poll_status(input logic [31:0] mask, input logic [31:0] want,
			input string what);
		logic [31:0] d;
		logic [1:0]  r;
		int          n;
		n = 0;
		do begin
			axil_read(A_STATUS, d, r);
			n++;
		end while ((d & mask) != want && n < 40);
		check_true((d & mask) == want, what);
	endtask

	task automatic load_key(input logic [127:0] key);
		aes_block_u k;
		k.flat = key;
		for (int i = 0; i < 4; i++)
			write_reg(A_KEY0 + 32'(4 * i), k.col[i]);   // KEY0 is the top word
		write_reg(A_CTRL, 32'h1);
	endtask

	task automatic run_block(input logic [127:0] pt);
		aes_block_u p;
		p.flat = pt;
		for (int i = 0; i < 4; i++)
			write_reg(A_DIN0 + 32'(4 * i), p.col[i]);
		write_reg(A_CTRL, 32'h2);
	endtask

	task automatic check_dout(input logic [127:0] ct);
		aes_block_u e;
		e.flat = ct;
		for (int i = 0; i < 4; i++)
			read_reg(A_DOUT0 + 32'(4 * i), e.col[i], $sformatf("DOUT%0d", i));
	endtask

	// ------------------------------------------------------------------------
	// sequence
	// ------------------------------------------------------------------------
	initial begin : main
		logic [31:0] d;
		logic [1:0]  r;
		i_rst     = 1'b1;
		i_aw      = '0;
		i_w       = '0;
		i_ar      = '0;
		i_b_ready = 1'b0;
		i_r_ready = 1'b0;
		rng       = 32'h31a45055;
		bp_en     = 1'b0;
		$readmemh("tb/aes_testdata.hex", vec_mem);
		for (int v = 0; v < NUM_VEC; v++)
			vecs[v] = {vec_mem[3*v], vec_mem[3*v+1], vec_mem[3*v+2]};
		repeat (2) @(posedge i_clk);
		#5;
		i_rst = 1'b0;
		check_true(!$isunknown(vec_mem[3*NUM_VEC-1]), "test data file missing or short");

		test_begin();
		read_reg(A_STATUS, 32'h0, "STATUS after reset");
		axil_read(A_UNMAPPED, d, r);
		check_eq("rresp unmapped", r, RESP_SLVERR);
		check_eq("rdata unmapped", d, 32'h0);
		axil_write(A_STATUS, 32'hf, r);   // read-only
		check_eq("bresp STATUS write", r, RESP_SLVERR);
		test_end("reset and decode");

		test_begin();
		write_reg(A_CTRL, 32'h2);   // no key yet
		read_reg(A_STATUS, ST_ERR, "STATUS after early start");
		load_key(vecs[0].key);
		poll_status(ST_KEY_OK, ST_KEY_OK, "key_ok never rose");
		read_reg(A_STATUS, ST_KEY_OK, "STATUS after key load");
		test_end("start before key");

		// the key changes between vectors so the lent S-box column goes back and forth
		bp_en = 1'b1;
		for (int v = 0; v < NUM_VEC; v++) begin
			test_begin();
			load_key(vecs[v].key);
			poll_status(ST_KEY_OK, ST_KEY_OK, "key_ok never rose");
			run_block(vecs[v].pt);
			poll_status(ST_BUSY | ST_DONE, ST_DONE, "done never set");
			check_dout(vecs[v].ct);
			test_end($sformatf("vector %0d", v));
		end

		// second start has to land inside the 10 rounds
		bp_en = 1'b0;
		test_begin();
		run_block(vecs[NUM_VEC-1].pt);
		write_reg(A_CTRL, 32'h2);
		poll_status(ST_BUSY | ST_DONE, ST_DONE, "done never set");
		read_reg(A_STATUS, ST_KEY_OK | ST_DONE | ST_ERR, "STATUS after busy start");
		check_dout(vecs[NUM_VEC-1].ct);
		load_key(vecs[NUM_VEC-1].key);
		poll_status(ST_KEY_OK, ST_KEY_OK, "key_ok never rose");
		read_reg(A_STATUS, ST_KEY_OK | ST_DONE, "STATUS after error clear");
		test_end("start while busy");

		test_begin();
		check_eq("B response count", n_b, n_wr);
		check_eq("R response count", n_r, n_rd);
		test_end("response counts");

		$display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/aes_testdata.hex
// one 128-bit field per line, three lines per vector
// key, plaintext, expected ciphertext
// FIPS-197 appendix C.1
000102030405060708090a0b0c0d0e0f
00112233445566778899aabbccddeeff
69c4e0d86a7b0430d8cdb78070b4c55a
// FIPS-197 appendix B
2b7e151628aed2a6abf7158809cf4f3c
3243f6a8885a308d313198a2e0370734
3925841d02dc09fbdc118597196a0b32
// SP 800-38A F.1.1 block 1
2b7e151628aed2a6abf7158809cf4f3c
6bc1bee22e409f96e93d7e117393172a
3ad77bb40d7a3660a89ecaf32466ef97
// SP 800-38A F.1.1 block 2
2b7e151628aed2a6abf7158809cf4f3c
ae2d8a571e03ac9c9eb76fac45af8e51
f5d3d58503b9699de785895a96fdbaaf

// File: filelist.f
common/aes_pkg.sv
common/axil_pkg.sv
aes/aes_sbox.sv
aes/aes_keyex.sv
aes/aes_cipher.sv
verilog/aes_regs.sv
verilog/aes_result.sv
verilog/aes_top.sv
tb/tb_aes_top.sv
